// File: source/rvCorePkg.sv
// RV32I core package with the ISA encodings, datapath word types and the NOP word
`default_nettype none

package rvCorePkg;

  ////////////////////////////////////////
  // Datapath types
  ////////////////////////////////////////
  typedef logic [31:0] wordT;   // PC, data, immediate, ALU result
  typedef logic [4:0]  regIdxT; // x0..x31

  ////////////////////////////////////////
  // Instruction encodings
  ////////////////////////////////////////

  // Major opcode field, instr[6:0]
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    STORE  = 7'b0100011,
    I_OP   = 7'b0010011,  // Register-immediate ALU
    R_OP   = 7'b0110011,  // Register-register ALU
    FENCE  = 7'b0001111   // Executes as NOP
  } opcodeT;

  // ALU function select
  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND
  } aluOpT;

  // Branch condition, same code as funct3
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branchT;

  // Immediate formats
  typedef enum logic [2:0] {
    I_TYPE,
    S_TYPE,
    B_TYPE,
    U_TYPE,
    J_TYPE
  } immTypeT;

  localparam wordT NOP = 32'h0000_0013; // addi x0, x0, 0

endpackage

`default_nettype wire

// File: source/fetchStage.sv
// Fetch stage holding the program counter and choosing sequential or redirect next PC
`timescale 1ns/10ps
`default_nettype none

module fetchStage import rvCorePkg::*; #(
  parameter wordT resetPc = 32'h0000_0000  // First fetch address
) (
  input  logic Clk,
  input  logic rstN,
  input  logic redirectQ102H,   // Taken branch or jump in execute
  input  wordT targetQ102H,     // Redirect address from the ALU
  output wordT pcQ100H,         // To instruction memory
  output wordT pcPlus4Q100H     // Sequential address, also the link value
);

  wordT nextPcQ100H;

  assign pcPlus4Q100H = pcQ100H + 32'd4;

  // JALR target has bit 0 cleared, branch and JAL targets are already even
  assign nextPcQ100H = redirectQ102H ? {targetQ102H[31:1], 1'b0} : pcPlus4Q100H;

  // PC moves every cycle, no stall source left
  always_ff @(posedge Clk) begin
    if (!rstN) begin
      pcQ100H <= resetPc;
    end else begin
      pcQ100H <= nextPcQ100H;
    end
  end

endmodule

`default_nettype wire

// File: source/decodeUnit.sv
// Decode stage logic producing control bits, ALU operation and immediate from an instruction
`timescale 1ns/10ps
`default_nettype none

module decodeUnit import rvCorePkg::*; (
  input  wordT   instructionQ101H,  // Fetched word
  input  logic   redirectQ102H,     // Redirect taken this cycle
  input  logic   redirectQ103H,     // Redirect taken last cycle
  output opcodeT opcodeQ101H,
  output aluOpT  aluOpQ101H,
  output branchT branchOpQ101H,
  output wordT   immediateQ101H,
  output regIdxT rs1Q101H,
  output regIdxT rs2Q101H,
  output regIdxT rdQ101H,
  output logic   selAluPcQ101H,     // ALU input 1 takes PC
  output logic   selAluImmQ101H,    // ALU input 2 takes immediate
  output logic   ctrlLuiQ101H,      // ALU passes the immediate
  output logic   isJumpQ101H,
  output logic   isBranchQ101H,
  output logic   regWrEnQ101H,
  output logic   storeEnQ101H
);

  wordT       instQ101H;
  logic [2:0] funct3Q101H;
  logic [6:0] funct7Q101H;
  immTypeT    immTypeQ101H;

  ////////////////////////////////////////
  // Flush
  ////////////////////////////////////////

  // Both slots fetched behind a redirect become bubbles
  assign instQ101H = (redirectQ102H || redirectQ103H) ? NOP : instructionQ101H;

  ////////////////////////////////////////
  // Field extraction and control
  ////////////////////////////////////////
  assign opcodeQ101H   = opcodeT'(instQ101H[6:0]);
  assign funct3Q101H   = instQ101H[14:12];
  assign funct7Q101H   = instQ101H[31:25];
  assign rdQ101H       = instQ101H[11:7];
  assign rs1Q101H      = instQ101H[19:15];
  assign rs2Q101H      = instQ101H[24:20];
  assign branchOpQ101H = branchT'(funct3Q101H);

  assign selAluPcQ101H  = (opcodeQ101H == JAL) || (opcodeQ101H == BRANCH) ||
                          (opcodeQ101H == AUIPC);
  assign selAluImmQ101H = (opcodeQ101H != R_OP); // Only reg-reg uses rs2
  assign ctrlLuiQ101H   = (opcodeQ101H == LUI);
  assign isJumpQ101H    = (opcodeQ101H == JAL) || (opcodeQ101H == JALR);
  assign isBranchQ101H  = (opcodeQ101H == BRANCH);
  assign regWrEnQ101H   = (opcodeQ101H == LUI)  || (opcodeQ101H == AUIPC) ||
                          (opcodeQ101H == JAL)  || (opcodeQ101H == JALR)  ||
                          (opcodeQ101H == I_OP) || (opcodeQ101H == R_OP); // FENCE writes nothing
  assign storeEnQ101H   = (opcodeQ101H == STORE) && (funct3Q101H == 3'b010); // SW only

  // ALU function, ADD for address, target and LUI paths
  always_comb begin
    aluOpQ101H = ADD;
    if ((opcodeQ101H == R_OP) || (opcodeQ101H == I_OP)) begin
      case (funct3Q101H)
        3'b000:  aluOpQ101H = ((opcodeQ101H == R_OP) && funct7Q101H[5]) ? SUB : ADD;
        3'b001:  aluOpQ101H = SLL;
        3'b010:  aluOpQ101H = SLT;
        3'b011:  aluOpQ101H = SLTU;
        3'b100:  aluOpQ101H = XOR;
        3'b101:  aluOpQ101H = funct7Q101H[5] ? SRA : SRL; // Bit 30 picks arithmetic
        3'b110:  aluOpQ101H = OR;
        3'b111:  aluOpQ101H = AND;
        default: aluOpQ101H = ADD;
      endcase
    end
  end

  ////////////////////////////////////////
  // Immediate generation
  ////////////////////////////////////////
  always_comb begin
    case (opcodeQ101H)
      LUI, AUIPC: immTypeQ101H = U_TYPE;
      JAL:        immTypeQ101H = J_TYPE;
      BRANCH:     immTypeQ101H = B_TYPE;
      STORE:      immTypeQ101H = S_TYPE;
      default:    immTypeQ101H = I_TYPE; // JALR, I_OP
    endcase
  end

  always_comb begin
    case (immTypeQ101H)
      S_TYPE:  immediateQ101H = {{20{instQ101H[31]}}, instQ101H[31:25], instQ101H[11:7]};
      B_TYPE:  immediateQ101H = {{20{instQ101H[31]}}, instQ101H[7], instQ101H[30:25],
                                 instQ101H[11:8], 1'b0};
      U_TYPE:  immediateQ101H = {instQ101H[31:12], 12'h000};
      J_TYPE:  immediateQ101H = {{12{instQ101H[31]}}, instQ101H[19:12], instQ101H[20],
                                 instQ101H[30:21], 1'b0};
      default: immediateQ101H = {{20{instQ101H[31]}}, instQ101H[31:20]}; // I format
    endcase
  end

endmodule

`default_nettype wire

// File: source/registerFile.sv
// Register file with 31 general registers, hardwired x0 and write-through read bypass
`timescale 1ns/10ps
`default_nettype none

module registerFile import rvCorePkg::*; (
  input  logic   Clk,
  input  regIdxT rs1,      // Read port 1 index
  input  regIdxT rs2,      // Read port 2 index
  output wordT   rdData1,
  output wordT   rdData2,
  input  logic   wrEn,     // Write-back enable
  input  regIdxT wrIdx,
  input  wordT   wrData
);

  wordT regs [31:1];  // No storage for x0
  logic bypass1;
  logic bypass2;

  // Writes to x0 dropped
  always_ff @(posedge Clk) begin
    if (wrEn && (wrIdx != 5'd0)) begin
      regs[wrIdx] <= wrData;
    end
  end

  // Same-cycle write shows up on the read
  assign bypass1 = wrEn && (wrIdx == rs1) && (rs1 != 5'd0);
  assign bypass2 = wrEn && (wrIdx == rs2) && (rs2 != 5'd0);

  assign rdData1 = bypass1          ? wrData :
                   (rs1 == 5'd0)    ? '0     :
                                      regs[rs1];

  assign rdData2 = bypass2          ? wrData :
                   (rs2 == 5'd0)    ? '0     :
                                      regs[rs2];

endmodule

`default_nettype wire

// File: source/executeStage.sv
// Execute stage with operand forwarding, ALU, branch compare and redirect generation
`timescale 1ns/10ps
`default_nettype none

module executeStage import rvCorePkg::*; (
  input  wordT   pcQ102H,
  input  regIdxT rs1Q102H,
  input  regIdxT rs2Q102H,
  input  wordT   rdData1Q102H,     // Register file value from decode
  input  wordT   rdData2Q102H,
  input  wordT   immediateQ102H,
  input  aluOpT  aluOpQ102H,
  input  branchT branchOpQ102H,
  input  logic   selAluPcQ102H,
  input  logic   selAluImmQ102H,
  input  logic   ctrlLuiQ102H,
  input  logic   isJumpQ102H,
  input  logic   isBranchQ102H,
  input  regIdxT regDstQ103H,      // Memory stage producer
  input  logic   regWrEnQ103H,
  input  wordT   wbDataQ103H,
  input  regIdxT regDstQ104H,      // Write-back stage producer
  input  logic   regWrEnQ104H,
  input  wordT   regWrDataQ104H,
  output wordT   aluOutQ102H,      // Result, store address or redirect target
  output wordT   storeDataQ102H,
  output logic   redirectQ102H
);

  logic fwd1Q103H, fwd1Q104H;
  logic fwd2Q103H, fwd2Q104H;
  wordT opA;             // Forwarded rs1
  wordT opB;             // Forwarded rs2
  wordT aluIn1;
  wordT aluIn2;
  logic [4:0] shamt;
  logic condMet;

  ////////////////////////////////////////
  // Forwarding
  ////////////////////////////////////////
  assign fwd1Q103H = regWrEnQ103H && (regDstQ103H == rs1Q102H) && (rs1Q102H != 5'd0);
  assign fwd1Q104H = regWrEnQ104H && (regDstQ104H == rs1Q102H) && (rs1Q102H != 5'd0);
  assign fwd2Q103H = regWrEnQ103H && (regDstQ103H == rs2Q102H) && (rs2Q102H != 5'd0);
  assign fwd2Q104H = regWrEnQ104H && (regDstQ104H == rs2Q102H) && (rs2Q102H != 5'd0);

  // Younger producer wins
  assign opA = fwd1Q103H ? wbDataQ103H    :
               fwd1Q104H ? regWrDataQ104H :
                           rdData1Q102H;
  assign opB = fwd2Q103H ? wbDataQ103H    :
               fwd2Q104H ? regWrDataQ104H :
                           rdData2Q102H;

  assign storeDataQ102H = opB;  // SW data

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////
  assign aluIn1 = selAluPcQ102H  ? pcQ102H        : opA;
  assign aluIn2 = selAluImmQ102H ? immediateQ102H : opB;
  assign shamt  = aluIn2[4:0];

  always_comb begin
    case (aluOpQ102H)
      SUB:     aluOutQ102H = aluIn1 - aluIn2;
      SLL:     aluOutQ102H = aluIn1 << shamt;
      SLT:     aluOutQ102H = {31'd0, $signed(aluIn1) < $signed(aluIn2)};
      SLTU:    aluOutQ102H = {31'd0, aluIn1 < aluIn2};
      XOR:     aluOutQ102H = aluIn1 ^ aluIn2;
      SRL:     aluOutQ102H = aluIn1 >> shamt;
      SRA:     aluOutQ102H = $signed(aluIn1) >>> shamt;
      OR:      aluOutQ102H = aluIn1 | aluIn2;
      AND:     aluOutQ102H = aluIn1 & aluIn2;
      default: aluOutQ102H = aluIn1 + aluIn2;  // ADD, addresses, targets
    endcase
    if (ctrlLuiQ102H) begin
      aluOutQ102H = aluIn2;  // LUI takes the U immediate as is
    end
  end

  ////////////////////////////////////////
  // Branch and redirect
  ////////////////////////////////////////
  always_comb begin
    case (branchOpQ102H)
      BEQ:     condMet = (opA == opB);
      BNE:     condMet = (opA != opB);
      BLT:     condMet = ($signed(opA) < $signed(opB));
      BGE:     condMet = ($signed(opA) >= $signed(opB));
      BLTU:    condMet = (opA < opB);
      BGEU:    condMet = (opA >= opB);
      default: condMet = 1'b0;  // Reserved funct3 never taken
    endcase
  end

  assign redirectQ102H = (isBranchQ102H && condMet) || isJumpQ102H;

endmodule

`default_nettype wire

// File: source/rvCore.sv
// Five-stage RV32I core top with stage registers, word store port and write-back select
`timescale 1ns/10ps
`default_nettype none

module rvCore import rvCorePkg::*; #(
  parameter wordT resetPc = 32'h0000_0000
) (
  input  logic Clk,
  input  logic rstN,
  output wordT pcQ100H,           // To instruction memory
  input  wordT instructionQ101H,  // Registered read of pcQ100H
  output logic dMemWrEnQ103H,     // One word store per high cycle
  output wordT dMemAddressQ103H,
  output wordT dMemWrDataQ103H
);

  wordT   pcPlus4Q100H;
  wordT   pcQ101H, pcPlus4Q101H, decInstQ101H;
  logic   fetchValidQ101H;        // Low for the stale word right after reset
  opcodeT opcodeQ101H;
  aluOpT  aluOpQ101H, aluOpQ102H;
  branchT branchOpQ101H, branchOpQ102H;
  wordT   immediateQ101H, immediateQ102H;
  regIdxT rs1Q101H, rs2Q101H, rdQ101H, rs1Q102H, rs2Q102H, rdQ102H;
  wordT   rdData1Q101H, rdData2Q101H, rdData1Q102H, rdData2Q102H;
  logic   selAluPcQ101H, selAluImmQ101H, ctrlLuiQ101H, isJumpQ101H, isBranchQ101H;
  logic   selAluPcQ102H, selAluImmQ102H, ctrlLuiQ102H, isJumpQ102H, isBranchQ102H;
  logic   regWrEnQ101H, regWrEnQ102H, regWrEnQ103H, regWrEnQ104H;
  logic   storeEnQ101H, storeEnQ102H, storeEnQ103H;
  logic   linkQ101H, linkQ102H, linkQ103H;  // Write PC+4 to rd
  wordT   pcQ102H, pcPlus4Q102H, pcPlus4Q103H;
  wordT   aluOutQ102H, aluOutQ103H, storeDataQ102H, storeDataQ103H;
  logic   redirectQ102H, redirectQ103H;
  regIdxT regDstQ103H, regDstQ104H;
  wordT   wbDataQ103H, regWrDataQ104H;

  ////////////////////////////////////////
  // Q100H fetch
  ////////////////////////////////////////
  fetchStage #(.resetPc(resetPc)) uFetch (
    .Clk(Clk), .rstN(rstN), .redirectQ102H(redirectQ102H), .targetQ102H(aluOutQ102H),
    .pcQ100H(pcQ100H), .pcPlus4Q100H(pcPlus4Q100H)
  );

  ////////////////////////////////////////
  // Q101H decode
  ////////////////////////////////////////
  assign decInstQ101H = fetchValidQ101H ? instructionQ101H : NOP;
  assign linkQ101H    = (opcodeQ101H == JAL) || (opcodeQ101H == JALR);

  decodeUnit uDecode (
    .instructionQ101H(decInstQ101H), .redirectQ102H(redirectQ102H),
    .redirectQ103H(redirectQ103H), .opcodeQ101H(opcodeQ101H), .aluOpQ101H(aluOpQ101H),
    .branchOpQ101H(branchOpQ101H), .immediateQ101H(immediateQ101H), .rs1Q101H(rs1Q101H),
    .rs2Q101H(rs2Q101H), .rdQ101H(rdQ101H), .selAluPcQ101H(selAluPcQ101H),
    .selAluImmQ101H(selAluImmQ101H), .ctrlLuiQ101H(ctrlLuiQ101H), .isJumpQ101H(isJumpQ101H),
    .isBranchQ101H(isBranchQ101H), .regWrEnQ101H(regWrEnQ101H), .storeEnQ101H(storeEnQ101H)
  );

  // Read in Q101H, write from Q104H
  registerFile uRegFile (
    .Clk(Clk), .rs1(rs1Q101H), .rs2(rs2Q101H), .rdData1(rdData1Q101H),
    .rdData2(rdData2Q101H), .wrEn(regWrEnQ104H), .wrIdx(regDstQ104H), .wrData(regWrDataQ104H)
  );

  ////////////////////////////////////////
  // Q102H execute
  ////////////////////////////////////////
  executeStage uExecute (
    .pcQ102H(pcQ102H), .rs1Q102H(rs1Q102H), .rs2Q102H(rs2Q102H),
    .rdData1Q102H(rdData1Q102H), .rdData2Q102H(rdData2Q102H), .immediateQ102H(immediateQ102H),
    .aluOpQ102H(aluOpQ102H), .branchOpQ102H(branchOpQ102H), .selAluPcQ102H(selAluPcQ102H),
    .selAluImmQ102H(selAluImmQ102H), .ctrlLuiQ102H(ctrlLuiQ102H), .isJumpQ102H(isJumpQ102H),
    .isBranchQ102H(isBranchQ102H), .regDstQ103H(regDstQ103H), .regWrEnQ103H(regWrEnQ103H),
    .wbDataQ103H(wbDataQ103H), .regDstQ104H(regDstQ104H), .regWrEnQ104H(regWrEnQ104H),
    .regWrDataQ104H(regWrDataQ104H), .aluOutQ102H(aluOutQ102H),
    .storeDataQ102H(storeDataQ102H), .redirectQ102H(redirectQ102H)
  );

  ////////////////////////////////////////
  // Q103H memory and write-back select
  ////////////////////////////////////////
  assign wbDataQ103H      = linkQ103H ? pcPlus4Q103H : aluOutQ103H; // Link or ALU
  assign dMemWrEnQ103H    = storeEnQ103H;
  assign dMemAddressQ103H = aluOutQ103H;
  assign dMemWrDataQ103H  = storeDataQ103H;

  // Payload registers
  always_ff @(posedge Clk) begin
    pcQ101H        <= pcQ100H;
    pcPlus4Q101H   <= pcPlus4Q100H;
    pcQ102H        <= pcQ101H;
    pcPlus4Q102H   <= pcPlus4Q101H;
    rs1Q102H       <= rs1Q101H;
    rs2Q102H       <= rs2Q101H;
    rdQ102H        <= rdQ101H;
    rdData1Q102H   <= rdData1Q101H;
    rdData2Q102H   <= rdData2Q101H;
    immediateQ102H <= immediateQ101H;
    aluOpQ102H     <= aluOpQ101H;
    branchOpQ102H  <= branchOpQ101H;
    selAluPcQ102H  <= selAluPcQ101H;
    selAluImmQ102H <= selAluImmQ101H;
    ctrlLuiQ102H   <= ctrlLuiQ101H;
    linkQ102H      <= linkQ101H;
    aluOutQ103H    <= aluOutQ102H;
    storeDataQ103H <= storeDataQ102H;
    pcPlus4Q103H   <= pcPlus4Q102H;
    regDstQ103H    <= rdQ102H;
    linkQ103H      <= linkQ102H;
    regDstQ104H    <= regDstQ103H;
    regWrDataQ104H <= wbDataQ103H;
  end

  // Control registers, cleared in reset
  always_ff @(posedge Clk) begin
    if (!rstN) begin
      fetchValidQ101H <= 1'b0;
      isJumpQ102H     <= 1'b0;
      isBranchQ102H   <= 1'b0;
      regWrEnQ102H    <= 1'b0;
      storeEnQ102H    <= 1'b0;
      regWrEnQ103H    <= 1'b0;
      storeEnQ103H    <= 1'b0;
      redirectQ103H   <= 1'b0;
      regWrEnQ104H    <= 1'b0;
    end else begin
      fetchValidQ101H <= 1'b1;
      isJumpQ102H     <= isJumpQ101H;
      isBranchQ102H   <= isBranchQ101H;
      regWrEnQ102H    <= regWrEnQ101H;
      storeEnQ102H    <= storeEnQ101H;
      regWrEnQ103H    <= regWrEnQ102H;
      storeEnQ103H    <= storeEnQ102H;
      redirectQ103H   <= redirectQ102H;  // Second flush slot
      regWrEnQ104H    <= regWrEnQ103H;
    end
  end

endmodule

`default_nettype wire

// File: test/rvCore_checker.sv
// Bound assertions on reset behaviour, PC alignment and the store strobe of the core
`timescale 1ns/10ps
`default_nettype none

module rvCoreChecker (
  input wire logic        Clk,
  input wire logic        rstN,
  input wire logic [31:0] pcQ100H,
  input wire logic        dMemWrEnQ103H
);

  int failCount = 0;  // Assertion failures so far

  // No store in reset nor in the first two cycles after it
  resetQuiet: assert property (@(posedge Clk) !rstN |=> !dMemWrEnQ103H [*3])
    else begin
      $error("store strobe active too early around reset");
      failCount++;
    end

  // Instruction fetch stays word aligned
  pcAligned: assert property (@(posedge Clk) disable iff (!rstN) pcQ100H[1:0] == 2'b00)
    else begin
      $error("pcQ100H not word aligned");
      failCount++;
    end

  // Strobe is always a clean 0 or 1 once running
  wrEnKnown: assert property (@(posedge Clk) disable iff (!rstN) !$isunknown(dMemWrEnQ103H))
    else begin
      $error("dMemWrEnQ103H unknown");
      failCount++;
    end

endmodule

bind rvCore rvCoreChecker uChecker (
  .Clk(Clk),
  .rstN(rstN),
  .pcQ100H(pcQ100H),
  .dMemWrEnQ103H(dMemWrEnQ103H)
);

`default_nettype wire

// File: test/rvCoreTb.sv
// Table-driven testbench running small programs on the core and checking every store
`timescale 1ns/10ps
`default_nettype none

module rvCoreTb;

  localparam logic [31:0] resetPc = 32'h0;
  localparam int numTests = 7;
  localparam int timeoutCycles = 200;  // Store collection limit per test
  localparam logic [31:0] nopWord = 32'h0000_0013;

  logic Clk;
  logic rstN;
  logic [31:0] pcQ100H, instructionQ101H, dMemAddressQ103H, dMemWrDataQ103H;
  logic dMemWrEnQ103H;
  logic [31:0] fetchPc;  // PC seen at the last rising edge

  logic [31:0] progMem [0:numTests-1][0:31];
  logic [31:0] expAddr [0:numTests-1][0:7];
  logic [31:0] expData [0:numTests-1][0:7];
  int expCount [0:numTests-1];
  int progLen [0:numTests-1];
  string rowName [0:numTests-1];
  logic [31:0] imem [0:31];
  int errors;
  int passedTests;

  rvCore #(.resetPc(resetPc)) i_dut (
    .Clk(Clk), .rstN(rstN), .pcQ100H(pcQ100H), .instructionQ101H(instructionQ101H),
    .dMemWrEnQ103H(dMemWrEnQ103H), .dMemAddressQ103H(dMemAddressQ103H),
    .dMemWrDataQ103H(dMemWrDataQ103H)
  );

  initial begin
    Clk = 1'b0;
    forever #2 Clk = ~Clk;  // 4 ns period
  end

  ////////////////////////////////////////
  // Instruction memory with one clock latency
  ////////////////////////////////////////
  always @(posedge Clk) fetchPc <= pcQ100H;

  always @(negedge Clk) begin
    if (fetchPc < 32'd128) instructionQ101H <= imem[fetchPc[6:2]];
    else instructionQ101H <= nopWord;  // Beyond program or unknown PC
  end

  ////////////////////////////////////////
  // RV32I encoders
  ////////////////////////////////////////
  function automatic logic [31:0] rTypeInstr(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] iTypeInstr(input logic [6:0] op, input logic [2:0] f3,
                                             input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] swInstr(input logic [4:0] rs2, rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};  // SW
  endfunction

  function automatic logic [31:0] branchInstr(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                              input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] jalInstr(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic addInstr(input int row, input logic [31:0] word);
    progMem[row][progLen[row]] = word;
    progLen[row]++;
  endtask

  task automatic expectStore(input int row, input logic [31:0] addr, input logic [31:0] data);
    expAddr[row][expCount[row]] = addr;
    expData[row][expCount[row]] = data;
    expCount[row]++;
  endtask

  ////////////////////////////////////////
  // Test table
  ////////////////////////////////////////
  task automatic buildTable();
    logic [11:0] rndA, rndB;
    logic [31:0] sum;
    logic [2:0] f3Taken [0:5];
    logic [4:0] aTaken [0:5], bTaken [0:5], aNot [0:5], bNot [0:5];
    f3Taken = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};  // BEQ BNE BLT BGE BLTU BGEU
    aTaken = '{5'd1, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1};    // x1 = -1, x2 = 1
    bTaken = '{5'd1, 5'd2, 5'd2, 5'd1, 5'd1, 5'd2};
    aNot = '{5'd1, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
    bNot = '{5'd2, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1};
    for (int r = 0; r < numTests; r++) begin
      progLen[r] = 0;
      expCount[r] = 0;
      for (int i = 0; i < 32; i++) progMem[r][i] = nopWord;
    end
    // Row 0 dependent ALU chain
    rowName[0] = "alu chain";
    addInstr(0, iTypeInstr(7'h13, 3'd0, 5'd1, 5'd0, 12'd5));    // x1 = 5
    addInstr(0, iTypeInstr(7'h13, 3'd0, 5'd2, 5'd1, 12'd7));    // x2 = 12
    addInstr(0, rTypeInstr(7'h00, 3'd0, 5'd3, 5'd1, 5'd2));     // x3 = 17
    addInstr(0, rTypeInstr(7'h20, 3'd0, 5'd4, 5'd3, 5'd1));     // x4 = 12
    addInstr(0, iTypeInstr(7'h13, 3'd1, 5'd5, 5'd4, 12'd3));    // x5 = 96
    addInstr(0, iTypeInstr(7'h13, 3'd4, 5'd6, 5'd5, 12'hfff));  // x6 = ~96
    addInstr(0, iTypeInstr(7'h13, 3'd5, 5'd7, 5'd6, 12'h404));  // srai by 4
    addInstr(0, iTypeInstr(7'h13, 3'd5, 5'd8, 5'd6, 12'd28));   // srli by 28
    addInstr(0, rTypeInstr(7'h00, 3'd2, 5'd9, 5'd7, 5'd1));     // Signed -7 < 5
    addInstr(0, rTypeInstr(7'h00, 3'd3, 5'd10, 5'd7, 5'd1));    // sltu through the bypass
    addInstr(0, swInstr(5'd3, 5'd0, 12'd0));
    addInstr(0, swInstr(5'd6, 5'd0, 12'd4));
    addInstr(0, swInstr(5'd7, 5'd0, 12'd8));
    addInstr(0, swInstr(5'd8, 5'd0, 12'd12));
    addInstr(0, swInstr(5'd9, 5'd0, 12'd16));
    addInstr(0, swInstr(5'd10, 5'd0, 12'd20));
    addInstr(0, swInstr(5'd5, 5'd0, 12'd24));
    expectStore(0, 32'd0, 32'd17);
    expectStore(0, 32'd4, 32'hffff_ff9f);
    expectStore(0, 32'd8, 32'hffff_fff9);
    expectStore(0, 32'd12, 32'h0000_000f);
    expectStore(0, 32'd16, 32'd1);
    expectStore(0, 32'd20, 32'd0);
    expectStore(0, 32'd24, 32'd96);
    // Row 1 random immediates checked against a sum and xor model
    rowName[1] = "random imm";
    rndA = 12'($urandom);
    rndB = 12'($urandom);
    sum = {{20{rndA[11]}}, rndA} + {{20{rndB[11]}}, rndB};
    addInstr(1, iTypeInstr(7'h13, 3'd0, 5'd1, 5'd0, rndA));
    addInstr(1, iTypeInstr(7'h13, 3'd0, 5'd2, 5'd0, rndB));
    addInstr(1, rTypeInstr(7'h00, 3'd0, 5'd3, 5'd1, 5'd2));
    addInstr(1, rTypeInstr(7'h00, 3'd4, 5'd4, 5'd3, 5'd1));
    addInstr(1, swInstr(5'd3, 5'd0, 12'h40));
    addInstr(1, swInstr(5'd4, 5'd0, 12'h44));
    expectStore(1, 32'h40, sum);
    expectStore(1, 32'h44, sum ^ {{20{rndA[11]}}, rndA});
    // Row 2 upper immediates
    rowName[2] = "lui auipc";
    addInstr(2, {20'h12345, 5'd1, 7'h37});                 // lui at PC 0
    addInstr(2, {20'h00010, 5'd2, 7'h17});                 // auipc at PC 4
    addInstr(2, swInstr(5'd1, 5'd0, 12'd0));
    addInstr(2, swInstr(5'd2, 5'd0, 12'd4));
    expectStore(2, 32'd0, 32'h1234_5000);
    expectStore(2, 32'd4, 32'h0001_0004);
    // Rows 3 and 4 branches with shadow stores to 0x80
    rowName[3] = "branch taken";
    rowName[4] = "branch not taken";
    for (int r = 3; r <= 4; r++) begin
      addInstr(r, iTypeInstr(7'h13, 3'd0, 5'd1, 5'd0, 12'hfff));
      addInstr(r, iTypeInstr(7'h13, 3'd0, 5'd2, 5'd0, 12'd1));
      addInstr(r, iTypeInstr(7'h13, 3'd0, 5'd4, 5'd0, 12'h55));
    end
    for (int i = 0; i < 6; i++) begin
      addInstr(3, branchInstr(f3Taken[i], aTaken[i], bTaken[i], 13'd12));
      addInstr(3, swInstr(5'd4, 5'd0, 12'h80));
      addInstr(3, swInstr(5'd4, 5'd0, 12'h80));
      addInstr(3, swInstr(5'd4, 5'd0, 12'(i * 4)));
      expectStore(3, 32'(i * 4), 32'h55);
      addInstr(4, branchInstr(f3Taken[i], aNot[i], bNot[i], 13'd8));  // Skips store if taken
      addInstr(4, swInstr(5'd4, 5'd0, 12'(i * 4)));
      expectStore(4, 32'(i * 4), 32'h55);
    end
    // Row 5 jumps with links
    rowName[5] = "jal jalr";
    addInstr(5, jalInstr(5'd1, 21'd16));                    // PC 0 to 16
    addInstr(5, swInstr(5'd0, 5'd0, 12'h80));
    addInstr(5, swInstr(5'd0, 5'd0, 12'h80));
    addInstr(5, nopWord);
    addInstr(5, swInstr(5'd1, 5'd0, 12'd0));                // PC 16
    addInstr(5, iTypeInstr(7'h13, 3'd0, 5'd5, 5'd0, 12'd40));
    addInstr(5, iTypeInstr(7'h67, 3'd0, 5'd6, 5'd5, 12'd0));  // PC 24 to 40
    addInstr(5, swInstr(5'd0, 5'd0, 12'h80));
    addInstr(5, swInstr(5'd0, 5'd0, 12'h80));
    addInstr(5, nopWord);
    addInstr(5, swInstr(5'd6, 5'd0, 12'd4));                // PC 40
    expectStore(5, 32'd0, 32'd4);
    expectStore(5, 32'd4, 32'd28);
    // Row 6 x0 stays zero
    rowName[6] = "x0 write";
    addInstr(6, iTypeInstr(7'h13, 3'd0, 5'd0, 5'd0, 12'd77));
    addInstr(6, swInstr(5'd0, 5'd0, 12'd0));                // Must not forward 77
    addInstr(6, iTypeInstr(7'h13, 3'd0, 5'd1, 5'd0, 12'd9));
    addInstr(6, swInstr(5'd1, 5'd0, 12'd4));
    expectStore(6, 32'd0, 32'd0);
    expectStore(6, 32'd4, 32'd9);
  endtask

  ////////////////////////////////////////
  // One table row
  ////////////////////////////////////////
  task automatic runTest(input int row);
    int cycles;
    int seen;
    int errBefore;
    errBefore = errors;
    for (int i = 0; i < 32; i++) imem[i] = progMem[row][i];
    rstN = 1'b0;
    repeat (4) @(negedge Clk);
    assert (pcQ100H === resetPc) else begin
      $display("ERR t=%0t pcQ100H got %h exp %h", $time, pcQ100H, resetPc);
      errors++;
    end
    rstN = 1'b1;
    seen = 0;
    cycles = 0;
    while (seen < expCount[row] && cycles < timeoutCycles) begin
      @(negedge Clk);
      cycles++;
      if (dMemWrEnQ103H === 1'b1) begin
        assert (dMemAddressQ103H === expAddr[row][seen]) else begin
          $display("ERR t=%0t dMemAddressQ103H got %h exp %h", $time,
                   dMemAddressQ103H, expAddr[row][seen]);
          errors++;
        end
        assert (dMemWrDataQ103H === expData[row][seen]) else begin
          $display("ERR t=%0t dMemWrDataQ103H got %h exp %h", $time,
                   dMemWrDataQ103H, expData[row][seen]);
          errors++;
        end
        seen++;
      end
    end
    if (seen < expCount[row]) begin
      $display("Test %0d timed out after %0d cycles with %0d of %0d stores", row, cycles,
               seen, expCount[row]);
      errors++;
    end
    // Quiet window over the NOP tail
    cycles = 0;
    while (cycles < 16) begin
      @(negedge Clk);
      cycles++;
      assert (dMemWrEnQ103H !== 1'b1) else begin
        $display("Test %0d made an unexpected extra store at time %0t", row, $time);
        errors++;
      end
    end
    if (errors == errBefore) passedTests++;
    $display("Test %0d (%s): %0d stores, %s", row, rowName[row], seen,
             (errors == errBefore) ? "ok" : "mismatch");
  endtask

  initial begin
    rstN = 1'b0;
    instructionQ101H = nopWord;
    errors = 0;
    passedTests = 0;
    void'($urandom(32'hf60b));
    buildTable();
    @(negedge Clk);
    for (int r = 0; r < numTests; r++) runTest(r);
    errors += i_dut.uChecker.failCount;
    $display("Tests run %0d, passed %0d, errors %0d", numTests, passedTests, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
source/rvCorePkg.sv
source/fetchStage.sv
source/decodeUnit.sv
source/registerFile.sv
source/executeStage.sv
source/rvCore.sv
test/rvCore_checker.sv
test/rvCoreTb.sv

// File: Bender.yml
package:
  name: rvCore

sources:
  - source/rvCorePkg.sv
  - source/fetchStage.sv
  - source/decodeUnit.sv
  - source/registerFile.sv
  - source/executeStage.sv
  - source/rvCore.sv
  - target: test
    files:
      - test/rvCore_checker.sv
      - test/rvCoreTb.sv
